// File: Bender.yml
package:
  name: alu_stream

sources:
  - hw/alu_stream_pkg.sv
  - hw/dec_exe_if.sv
  - hw/exe_res_if.sv
  - hw/skid_buffer.sv
  - hw/cmd_decode.sv
  - hw/alu_execute.sv
  - hw/result_format.sv
  - hw/alu_stream_top.sv
  - target: simulation
    files:
      - dv/alu_checker.sv
      - dv/tb_alu_stream.sv

// File: dv/alu_checker.sv
`timescale 1ns/1ps

module alu_checker
    import alu_stream_pkg::*;
    (
        input  wire logic              clk_i,
        input  wire logic              arst_n_i,
        input  wire logic              cmd_valid_i,
        input  wire logic              cmd_ready_i,   // DUT cmd_ready_o
        input  wire logic [OPC_W-1:0]  cmd_opcode_i,
        input  wire logic [DATA_W-1:0] cmd_a_i,
        input  wire logic [DATA_W-1:0] cmd_b_i,
        input  wire logic              rsp_valid_i,   // DUT rsp_valid_o
        input  wire logic              rsp_ready_i,
        input  wire logic [DATA_W-1:0] rsp_result_i,
        input  wire logic              rsp_carry_i,
        input  wire logic              rsp_zero_i,
        input  wire logic              rsp_error_i,
        output      int                errors_o,
        output      int                pending_o
    );

    logic [RSP_W-1:0] expect_q [$];    // {result, carry, zero, error} in command order
    logic [RSP_W-1:0] expected;
    logic [RSP_W-1:0] held;            // response seen last cycle
    logic             stalled = 1'b0;  // valid and not ready last cycle
    logic             reset_seen = 1'b0;
    int               errors = 0;

    // reference model built from the opcode table
    function automatic logic [RSP_W-1:0] predict_rsp(input logic [OPC_W-1:0] opc,
                                                    input logic [DATA_W-1:0] a,
                                                    input logic [DATA_W-1:0] b);
        logic [DATA_W:0]   wide;
        logic [DATA_W-1:0] res;
        logic              cy;
        cy = 1'b0;  // only add and subtract set it
        case (opc)
            OP_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                res  = wide[DATA_W-1:0];
                cy   = wide[DATA_W];
            end
            OP_SUB: begin
                res = a - b;
                cy  = (a < b);  // borrow
            end
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SHL:  res = a << b[2:0];
            OP_SHR:  res = a >> b[2:0];
            OP_PASS: res = a;
            default: return {{DATA_W{1'b0}}, 3'b001};  // illegal, error only
        endcase
        return {res, cy, (res == '0), 1'b0};
    endfunction

    task automatic compare_field(input string name, input logic [DATA_W-1:0] exp,
                                 input logic [DATA_W-1:0] act);
        if (exp !== act) begin
            $display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_rsp(input logic [RSP_W-1:0] exp, input string tag);
        compare_field({"rsp_result_o", tag}, exp[RSP_W-1:3], rsp_result_i);
        compare_field({"rsp_carry_o", tag}, exp[2], rsp_carry_i);
        compare_field({"rsp_zero_o", tag}, exp[1], rsp_zero_i);
        compare_field({"rsp_error_o", tag}, exp[0], rsp_error_i);
    endtask

    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            reset_seen = 1'b0;
            stalled    = 1'b0;
        end else begin
            if (!reset_seen) begin  // first edge out of reset
                compare_field("cmd_ready_o after reset", 1'b1, cmd_ready_i);
                compare_field("rsp_valid_o after reset", 1'b0, rsp_valid_i);
                reset_seen = 1'b1;
            end
            if (stalled) begin
                if (!rsp_valid_i) begin
                    $display("at %0t ns rsp_valid_o fell before the response was taken", $time);
                    errors++;
                end else begin
                    compare_rsp(held, " while stalled");
                end
            end
            if (cmd_valid_i && cmd_ready_i) begin
                expect_q.push_back(predict_rsp(cmd_opcode_i, cmd_a_i, cmd_b_i));
            end
            if (rsp_valid_i && rsp_ready_i) begin
                if (expect_q.size() == 0) begin
                    $display("at %0t ns a response came out with no command outstanding", $time);
                    errors++;
                end else begin
                    expected = expect_q.pop_front();
                    compare_rsp(expected, "");
                end
            end
            stalled = rsp_valid_i && !rsp_ready_i;
            held    = {rsp_result_i, rsp_carry_i, rsp_zero_i, rsp_error_i};
        end
        errors_o  = errors;
        pending_o = expect_q.size();
    end

endmodule

// File: dv/tb_alu_stream.sv
`timescale 1ns/1ps

module tb_alu_stream
    import alu_stream_pkg::*;
    ();

    localparam int NUM_CMDS    = 500;  // commands per run
    localparam int WAIT_LIMIT  = 100;  // cycles a command may wait for cmd_ready_o
    localparam int DRAIN_LIMIT = 200;  // cycles to empty the pipeline at the end

    logic              clk_i;
    logic              arst_n_i;
    logic              cmd_valid_i;
    logic              cmd_ready_o;
    logic [OPC_W-1:0]  cmd_opcode_i;
    logic [DATA_W-1:0] cmd_a_i;
    logic [DATA_W-1:0] cmd_b_i;
    logic              rsp_valid_o;
    logic              rsp_ready_i;
    logic [DATA_W-1:0] rsp_result_o;
    logic              rsp_carry_o;
    logic              rsp_zero_o;
    logic              rsp_error_o;

    int          errors;
    int          pending;   // responses the checker still expects
    logic [15:0] lfsr = 16'd70;
    logic [15:0] bits;
    int          sent;
    int          waited;
    int          drained;
    logic        accepted;  // handshake will happen at the coming edge
    logic        timed_out;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);       // one step per bit
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    alu_stream_top DUT (.*);

    alu_checker u_checker (
        .clk_i (clk_i), .arst_n_i (arst_n_i),
        .cmd_valid_i (cmd_valid_i), .cmd_ready_i (cmd_ready_o),
        .cmd_opcode_i (cmd_opcode_i), .cmd_a_i (cmd_a_i), .cmd_b_i (cmd_b_i),
        .rsp_valid_i (rsp_valid_o), .rsp_ready_i (rsp_ready_i),
        .rsp_result_i (rsp_result_o), .rsp_carry_i (rsp_carry_o),
        .rsp_zero_i (rsp_zero_o), .rsp_error_i (rsp_error_o),
        .errors_o (errors), .pending_o (pending)
    );

    initial begin
        arst_n_i     = 1'b0;
        cmd_valid_i  = 1'b0;
        cmd_opcode_i = '0;
        cmd_a_i      = '0;
        cmd_b_i      = '0;
        rsp_ready_i  = 1'b0;
        sent         = 0;
        waited       = 0;
        accepted     = 1'b0;
        timed_out    = 1'b0;
        repeat (8) @(posedge clk_i);
        #10 arst_n_i = 1'b1;

        while (sent < NUM_CMDS && !timed_out) begin
            @(posedge clk_i);
            #10;
            if (accepted) begin
                cmd_valid_i = 1'b0;  // taken at this edge
                sent++;
                waited = 0;
            end else if (cmd_valid_i) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    $display("timeout: command %0d not accepted within %0d cycles",
                             sent, WAIT_LIMIT);
                    timed_out = 1'b1;
                end
            end
            take_bits(2, bits);
            rsp_ready_i = (bits[1:0] != 2'b00);  // ready three cycles in four
            if (!cmd_valid_i && sent < NUM_CMDS) begin
                take_bits(2, bits);
                if (bits[1:0] != 2'b00) begin    // else leave a gap
                    take_bits(4, bits);
                    cmd_opcode_i = bits[3:0];    // all 16 codes, illegal ones too
                    take_bits(8, bits);
                    cmd_a_i = bits[7:0];
                    take_bits(8, bits);
                    cmd_b_i = bits[7:0];
                    cmd_valid_i = 1'b1;
                end
            end
            accepted = cmd_valid_i && cmd_ready_o;  // ready is registered, stable to the edge
        end

        drained = 0;
        while (pending != 0 && !timed_out) begin
            @(posedge clk_i);
            #10;
            take_bits(2, bits);
            rsp_ready_i = (bits[1:0] != 2'b00);
            drained++;
            if (drained > DRAIN_LIMIT) begin
                $display("timeout: %0d responses still outstanding after %0d cycles",
                         pending, DRAIN_LIMIT);
                timed_out = 1'b1;
            end
        end
        rsp_ready_i = 1'b1;
        repeat (10) @(posedge clk_i);  // any extra response shows up here

        $display("closing: %0d errors, %0d responses outstanding", errors, pending);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/alu_stream_pkg.sv
hw/dec_exe_if.sv
hw/exe_res_if.sv
hw/skid_buffer.sv
hw/cmd_decode.sv
hw/alu_execute.sv
hw/result_format.sv
hw/alu_stream_top.sv
dv/alu_checker.sv
dv/tb_alu_stream.sv

// File: hw/alu_execute.sv
`timescale 1ns/1ps

module alu_execute
    import alu_stream_pkg::*;
    (
        input  wire logic   clk_i,
        input  wire logic   arst_n_i,
        dec_exe_if.consumer in,
        exe_res_if.producer out
    );

    logic              valid_r;    // slot occupied
    logic [DATA_W-1:0] result_r;
    logic              carry_r;
    logic              illegal_r;

    logic [DATA_W:0]   sum;        // adder with carry out in the top bit
    logic [DATA_W-1:0] result_d;
    logic              carry_d;
    logic              accept;

    // shared adder for add and subtract
    assign sum = {1'b0, in.operand_a} + {1'b0, in.operand_b} + {{DATA_W{1'b0}}, in.carry_in};

    always_comb begin
        result_d = '0;
        carry_d  = 1'b0;  // logic and shift ops give no carry
        if (!in.illegal) begin
            case (in.op)
                ALU_ADD: begin
                    result_d = sum[DATA_W-1:0];
                    carry_d  = in.sub ? !sum[DATA_W] : sum[DATA_W];  // borrow on subtract
                end
                ALU_AND:  result_d = in.operand_a & in.operand_b;
                ALU_OR:   result_d = in.operand_a | in.operand_b;
                ALU_XOR:  result_d = in.operand_a ^ in.operand_b;
                ALU_SHL:  result_d = in.operand_a << in.operand_b[2:0];
                ALU_SHR:  result_d = in.operand_a >> in.operand_b[2:0];
                ALU_PASS: result_d = in.operand_a;
                default:  result_d = '0;
            endcase
        end
    end

    assign in.ready = !valid_r || out.ready;
    assign accept   = in.valid && in.ready;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_r <= 1'b0;
        end else if (accept) begin
            valid_r <= 1'b1;
        end else if (out.ready) begin
            valid_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            result_r  <= result_d;
            carry_r   <= carry_d;
            illegal_r <= in.illegal;  // carried on to the result stage
        end
    end

    assign out.valid   = valid_r;
    assign out.result  = result_r;
    assign out.carry   = carry_r;
    assign out.illegal = illegal_r;

endmodule

// File: hw/alu_stream_pkg.sv
package alu_stream_pkg;

    // widths
    localparam int unsigned DATA_W = 8;   // operand and result width
    localparam int unsigned OPC_W  = 4;   // command opcode width
    localparam int unsigned CMD_W  = OPC_W + 2 * DATA_W;  // 20 bits
    localparam int unsigned RSP_W  = DATA_W + 3;           // 11 bits

    // command opcodes, 8..15 left unnamed and treated as illegal
    typedef enum logic [OPC_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SHL  = 4'd5,
        OP_SHR  = 4'd6,
        OP_PASS = 4'd7
    } opcode_e;

    // internal operation classes seen by execute
    // subtract runs on the adder, with b inverted and carry in set by decode
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_AND  = 3'd1,
        ALU_OR   = 3'd2,
        ALU_XOR  = 3'd3,
        ALU_SHL  = 3'd4,
        ALU_SHR  = 3'd5,
        ALU_PASS = 3'd6
    } alu_op_e;

    // command word as it travels through the input skid buffer
    // opcode is kept as a plain vector so that illegal codes survive
    typedef struct packed {
        logic [OPC_W-1:0]  opcode;  // raw opcode, may be illegal
        logic [DATA_W-1:0] a;       // operand a
        logic [DATA_W-1:0] b;       // operand b, shift amount in b[2:0]
    } cmd_word_t;

    // response word as it travels through the output skid buffer
    typedef struct packed {
        logic [DATA_W-1:0] result;  // 8-bit result
        logic              carry;   // carry out, or borrow on subtract
        logic              zero;    // result is zero, legal items only
        logic              error;   // illegal opcode
    } rsp_word_t;

endpackage

// File: hw/alu_stream_top.sv
`timescale 1ns/1ps

module alu_stream_top
    import alu_stream_pkg::*;
    (
        input  wire logic              clk_i,
        input  wire logic              arst_n_i,

        // command side
        input  wire logic              cmd_valid_i,
        output      logic              cmd_ready_o,
        input  wire logic [OPC_W-1:0]  cmd_opcode_i,
        input  wire logic [DATA_W-1:0] cmd_a_i,
        input  wire logic [DATA_W-1:0] cmd_b_i,

        // response side
        output      logic              rsp_valid_o,
        input  wire logic              rsp_ready_i,
        output      logic [DATA_W-1:0] rsp_result_o,
        output      logic              rsp_carry_o,
        output      logic              rsp_zero_o,
        output      logic              rsp_error_o
    );

    cmd_word_t cmd_word_in;   // packed from the ports
    cmd_word_t dec_word;      // skid to decode
    logic      dec_valid;
    logic      dec_ready;

    rsp_word_t fmt_word;      // result stage to output skid
    logic      fmt_valid;
    logic      fmt_ready;
    rsp_word_t rsp_word_out;  // unpacked onto the ports

    dec_exe_if dec_exe ();
    exe_res_if exe_res ();

    assign cmd_word_in.opcode = cmd_opcode_i;
    assign cmd_word_in.a      = cmd_a_i;
    assign cmd_word_in.b      = cmd_b_i;

    skid_buffer #(.WORD_WIDTH(CMD_W)) u_cmd_skid (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .write_ready_o (cmd_ready_o),
        .write_valid_i (cmd_valid_i),
        .write_data_i  (cmd_word_in),
        .read_ready_i  (dec_ready),
        .read_valid_o  (dec_valid),
        .read_data_o   (dec_word)
    );

    cmd_decode u_decode (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cmd_valid_i (dec_valid),
        .cmd_ready_o (dec_ready),
        .cmd_word_i  (dec_word),
        .out         (dec_exe)
    );

    alu_execute u_execute (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .in       (dec_exe),
        .out      (exe_res)
    );

    result_format u_result (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in          (exe_res),
        .rsp_valid_o (fmt_valid),
        .rsp_ready_i (fmt_ready),
        .rsp_word_o  (fmt_word)
    );

    skid_buffer #(.WORD_WIDTH(RSP_W)) u_rsp_skid (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .write_ready_o (fmt_ready),
        .write_valid_i (fmt_valid),
        .write_data_i  (fmt_word),
        .read_ready_i  (rsp_ready_i),
        .read_valid_o  (rsp_valid_o),
        .read_data_o   (rsp_word_out)
    );

    assign rsp_result_o = rsp_word_out.result;
    assign rsp_carry_o  = rsp_word_out.carry;
    assign rsp_zero_o   = rsp_word_out.zero;
    assign rsp_error_o  = rsp_word_out.error;

endmodule

// File: hw/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode
    import alu_stream_pkg::*;
    (
        input  wire logic      clk_i,
        input  wire logic      arst_n_i,
        input  wire logic      cmd_valid_i,
        output      logic      cmd_ready_o,
        input  wire cmd_word_t cmd_word_i,
        dec_exe_if.producer    out
    );

    logic              valid_r;    // slot occupied
    alu_op_e           op_r;
    logic [DATA_W-1:0] a_r;
    logic [DATA_W-1:0] b_r;
    logic              cin_r;
    logic              sub_r;
    logic              illegal_r;

    alu_op_e           op_d;       // decoded next values
    logic [DATA_W-1:0] b_d;
    logic              cin_d;
    logic              sub_d;
    logic              illegal_d;
    logic              accept;

    // opcode map
    always_comb begin
        op_d      = ALU_PASS;
        b_d       = cmd_word_i.b;
        cin_d     = 1'b0;
        sub_d     = 1'b0;
        illegal_d = 1'b0;
        case (cmd_word_i.opcode)
            OP_ADD:  op_d = ALU_ADD;
            OP_SUB: begin
                op_d  = ALU_ADD;       // a + ~b + 1
                b_d   = ~cmd_word_i.b;
                cin_d = 1'b1;
                sub_d = 1'b1;
            end
            OP_AND:  op_d = ALU_AND;
            OP_OR:   op_d = ALU_OR;
            OP_XOR:  op_d = ALU_XOR;
            OP_SHL:  op_d = ALU_SHL;
            OP_SHR:  op_d = ALU_SHR;
            OP_PASS: op_d = ALU_PASS;
            default: illegal_d = 1'b1;  // 8..15
        endcase
    end

    assign cmd_ready_o = !valid_r || out.ready;  // empty slot or slot drains now
    assign accept      = cmd_valid_i && cmd_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_r <= 1'b0;
        end else if (accept) begin
            valid_r <= 1'b1;
        end else if (out.ready) begin
            valid_r <= 1'b0;  // item left, nothing new
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_r      <= op_d;
            a_r       <= cmd_word_i.a;
            b_r       <= b_d;
            cin_r     <= cin_d;
            sub_r     <= sub_d;
            illegal_r <= illegal_d;
        end
    end

    assign out.valid     = valid_r;
    assign out.op        = op_r;
    assign out.operand_a = a_r;
    assign out.operand_b = b_r;
    assign out.carry_in  = cin_r;
    assign out.sub       = sub_r;
    assign out.illegal   = illegal_r;

endmodule

// File: hw/dec_exe_if.sv
`timescale 1ns/1ps

interface dec_exe_if
    import alu_stream_pkg::*;
    ();

    logic              valid;      // decode holds an item
    logic              ready;      // execute can take it
    alu_op_e           op;         // operation class
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;  // already inverted on subtract
    logic              carry_in;   // adder carry in, 1 on subtract
    logic              sub;        // item is a subtract
    logic              illegal;    // opcode 8..15

    // decode side
    modport producer (output valid, op, operand_a, operand_b, carry_in, sub, illegal,
                      input  ready);

    // execute side
    modport consumer (input  valid, op, operand_a, operand_b, carry_in, sub, illegal,
                      output ready);

endinterface

// File: hw/exe_res_if.sv
`timescale 1ns/1ps

interface exe_res_if
    import alu_stream_pkg::*;
    ();

    logic              valid;    // execute holds an item
    logic              ready;    // result stage can take it
    logic [DATA_W-1:0] result;   // raw result, 0 on illegal
    logic              carry;    // carry or borrow
    logic              illegal;  // passed through from decode

    // execute side
    modport producer (output valid, result, carry, illegal,
                      input  ready);

    // result stage side
    modport consumer (input  valid, result, carry, illegal,
                      output ready);

    // nothing else travels here, flags are formed downstream

endinterface

// File: hw/result_format.sv
`timescale 1ns/1ps

module result_format
    import alu_stream_pkg::*;
    (
        input  wire logic   clk_i,
        input  wire logic   arst_n_i,
        exe_res_if.consumer in,
        output      logic      rsp_valid_o,
        input  wire logic      rsp_ready_i,
        output      rsp_word_t rsp_word_o
    );

    logic      valid_r;  // slot occupied
    rsp_word_t word_r;
    rsp_word_t word_d;
    logic      accept;

    // flags
    always_comb begin
        if (in.illegal) begin
            word_d.result = '0;  // error response carries no data
            word_d.carry  = 1'b0;
            word_d.zero   = 1'b0;
            word_d.error  = 1'b1;
        end else begin
            word_d.result = in.result;
            word_d.carry  = in.carry;
            word_d.zero   = (in.result == '0);
            word_d.error  = 1'b0;
        end
    end

    assign in.ready = !valid_r || rsp_ready_i;
    assign accept   = in.valid && in.ready;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_r <= 1'b0;
        end else if (accept) begin
            valid_r <= 1'b1;
        end else if (rsp_ready_i) begin
            valid_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            word_r <= word_d;
        end
    end

    assign rsp_valid_o = valid_r;
    assign rsp_word_o  = word_r;  // into the output skid buffer

endmodule

// File: hw/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer
    #(
        parameter int unsigned WORD_WIDTH = 8
    )
    (
        input  wire logic                  clk_i,
        input  wire logic                  arst_n_i,

        // write side
        output      logic                  write_ready_o,
        input  wire logic                  write_valid_i,
        input  wire logic [WORD_WIDTH-1:0] write_data_i,

        // read side
        input  wire logic                  read_ready_i,
        output      logic                  read_valid_o,
        output      logic [WORD_WIDTH-1:0] read_data_o
    );

    // empty   -> running on load
    // running -> running on run (write and read together)
    // running -> full    on buffer, running -> empty on unload
    // full    -> running on unbuffer
    typedef enum logic [1:0] {
        ST_EMPTY   = 2'b00,  // nothing in the output register
        ST_RUNNING = 2'b01,  // output register holds a word, side buffer free
        ST_FULL    = 2'b10   // both registers hold a word, writes stalled
    } state_t;

    state_t state_r;
    state_t state_next;

    logic write_ready_r;
    logic read_valid_r;

    logic [WORD_WIDTH-1:0] out_data_r;   // output register
    logic [WORD_WIDTH-1:0] side_data_r;  // skid register

    logic insert;  // write handshake this cycle
    logic remove;  // read handshake this cycle

    logic load;
    logic unload;
    logic buffer;
    logic unbuffer;
    logic run;

    assign insert = write_valid_i && write_ready_r;
    assign remove = read_valid_r && read_ready_i;

    always_comb begin
        load     = (state_r == ST_EMPTY)   &&  insert;
        unload   = (state_r == ST_RUNNING) && !insert &&  remove;  // last word leaves
        buffer   = (state_r == ST_RUNNING) &&  insert && !remove;  // reader stalled, use skid
        unbuffer = (state_r == ST_FULL)    &&  remove;             // refill from skid
        run      = (state_r == ST_RUNNING) &&  insert &&  remove;  // straight through
    end

    always_comb begin
        state_next = state_r;  // hold by default
        if (load || unbuffer) begin
            state_next = ST_RUNNING;
        end else if (buffer) begin
            state_next = ST_FULL;
        end else if (unload) begin
            state_next = ST_EMPTY;
        end
    end

    // control state, ready and valid are registered from the next state
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_r       <= ST_EMPTY;
            write_ready_r <= 1'b1;  // accept right after reset
            read_valid_r  <= 1'b0;
        end else begin
            state_r       <= state_next;
            write_ready_r <= (state_next != ST_FULL);   // drops one cycle after filling
            read_valid_r  <= (state_next != ST_EMPTY);
        end
    end

    // data path
    always_ff @(posedge clk_i) begin
        if (load || run) begin
            out_data_r <= write_data_i;  // new word goes straight to the output
        end else if (unbuffer) begin
            out_data_r <= side_data_r;   // skid word moves up
        end
        if (buffer) begin
            side_data_r <= write_data_i; // park the word while the reader stalls
        end
    end

    assign write_ready_o = write_ready_r;
    assign read_valid_o  = read_valid_r;
    assign read_data_o   = out_data_r;   // stable while valid and not taken

endmodule
